/* common/fft_defs.svh */
/*
  sizes and widths shared by the 16-point streaming FFT
  the sample, accumulator and bin widths all derive from here
*/
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////////////////////
`define FFT_N      16   // points per frame
`define FFT_STAGES 4    // log2 of FFT_N, one radix-2 stage each

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////
`define SAMPLE_W   16   // raw input sample
// internal re/im parts: 16 bit input + 4 bits of growth + margin
`define ACC_W      24
`define TW_FRAC    16   // twiddles are Q16
`define BIN_W      16   // each half of an output bin

// output bin packs re in the upper half, im in the lower
`define BIN_PAIR_W (2 * `BIN_W)

`endif

/* common/fft_pkg.sv */
/*
  FFT types and arithmetic helpers
  twiddle table, bit reversal, rounding multiply and output saturation
*/
`include "fft_defs.svh"

package fft_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  typedef logic signed [`ACC_W-1:0]    acc_t;
  typedef logic signed [31:0]          tw_t;     // Q16 twiddle part

  typedef struct packed {
    acc_t re;
    acc_t im;
  } cplx_t;                                      // 48 bits

  typedef cplx_t [`FFT_N-1:0] frame_t;           // 768 bits
  typedef logic [`BIN_PAIR_W-1:0] bin_t;         // {re, im}

  localparam int BIN_MAX = (1 << (`BIN_W - 1)) - 1;
  localparam int BIN_MIN = -(1 << (`BIN_W - 1));

  ////////////////////////////////////////////////////////////////////////////
  // twiddle table W^k = cos - j*sin, k = 0..7 of 16
  ////////////////////////////////////////////////////////////////////////////
  function automatic tw_t tw_re(input logic [2:0] k);
    case (k)
      3'd0: return 32'sh0001_0000;               // 1.0
      3'd1: return 32'sh0000_EC83;
      3'd2: return 32'sh0000_B504;
      3'd3: return 32'sh0000_61F7;
      3'd4: return 32'sh0000_0000;
      3'd5: return 32'shFFFF_9E09;
      3'd6: return 32'shFFFF_4AFC;
      default: return 32'shFFFF_137D;
    endcase
  endfunction

  function automatic tw_t tw_im(input logic [2:0] k);
    case (k)
      3'd0: return 32'sh0000_0000;
      3'd1: return 32'shFFFF_9E09;
      3'd2: return 32'shFFFF_4AFC;
      3'd3: return 32'shFFFF_137D;
      3'd4: return 32'shFFFF_0000;               // -1.0
      3'd5: return 32'shFFFF_137D;
      3'd6: return 32'shFFFF_4AFC;
      default: return 32'shFFFF_9E09;
    endcase
  endfunction

  // DIF stages leave the bins in bit-reversed order
  function automatic logic [3:0] bit_reverse(input logic [3:0] idx);
    return {idx[0], idx[1], idx[2], idx[3]};
  endfunction

  // real product, round half up then drop the twiddle fraction
  function automatic acc_t twiddle_mul(input acc_t d, input tw_t w);
    logic signed [`ACC_W+31:0] prod;
    prod = d * w;
    prod = prod + (1 <<< (`TW_FRAC - 1));
    return acc_t'(prod >>> `TW_FRAC);
  endfunction

  // clamp to the signed output range
  function automatic logic signed [`BIN_W-1:0] narrow_bin(input acc_t v);
    if (v > BIN_MAX) return BIN_MAX[`BIN_W-1:0];
    if (v < BIN_MIN) return BIN_MIN[`BIN_W-1:0];
    return v[`BIN_W-1:0];
  endfunction

endpackage

/* fft_stages/butterfly_stage.sv */
/*
  one radix-2 decimation-in-frequency stage
  eight butterflies across the frame, result held in a one-frame register
  with valid/ready toward the next stage
*/
`timescale 1ns/1ps
`include "fft_defs.svh"

module butterfly_stage
  import fft_pkg::*;
#(
  parameter int STAGE = 0      // 0 is the first stage
) (
  input  logic   clk,
  input  logic   rst,
  input  frame_t in_frame,
  input  logic   in_valid,
  output logic   in_ready,
  output frame_t out_frame,
  output logic   out_valid,
  input  logic   out_ready
);

  // distance between butterfly legs, halves every stage
  localparam int SPAN      = (`FFT_N / 2) >> STAGE;
  // step through the twiddle table, doubles every stage
  localparam int TW_STRIDE = 1 << STAGE;

  frame_t nxt_frame;            // combinational stage result
  logic   load;

  ////////////////////////////////////////////////////////////////////////////
  // butterflies
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin : butterflies
    int   lo;                   // upper leg index
    int   hi;                   // lower leg index
    int   k;                    // twiddle exponent
    acc_t dr;
    acc_t di;
    tw_t  wr;
    tw_t  wi;
    nxt_frame = in_frame;
    for (int b = 0; b < `FFT_N / 2; b++) begin
      // block base plus offset inside the block
      lo = (b / SPAN) * 2 * SPAN + (b % SPAN);
      hi = lo + SPAN;
      k  = (b % SPAN) * TW_STRIDE;  // stays below 8 for every stage
      wr = tw_re(k[2:0]);
      wi = tw_im(k[2:0]);

      // sum leg is exact
      nxt_frame[lo].re = in_frame[lo].re + in_frame[hi].re;
      nxt_frame[lo].im = in_frame[lo].im + in_frame[hi].im;

      // difference leg gets rotated by W^k
      dr = in_frame[lo].re - in_frame[hi].re;
      di = in_frame[lo].im - in_frame[hi].im;
      nxt_frame[hi].re = twiddle_mul(dr, wr) - twiddle_mul(di, wi);
      nxt_frame[hi].im = twiddle_mul(dr, wi) + twiddle_mul(di, wr);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // holding register
  ////////////////////////////////////////////////////////////////////////////
  // free when empty or when the held frame leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;                       // new frame, one cycle latency
    end else if (out_ready) begin
      out_valid <= 1'b0;                       // drained, nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      out_frame <= nxt_frame;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // a stalled frame must not change under the next stage
  hold_while_stalled: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_frame)
  ) else $error("stage %0d frame changed while stalled", STAGE);

endmodule

/* files.f */
+incdir+common
common/fft_pkg.sv
fft_stages/butterfly_stage.sv
hdl/sample_collector.sv
hdl/bin_serializer.sv
hdl/fft_top.sv
verification/fft_tb.sv

/* hdl/bin_serializer.sv */
/*
  bin serializer
  takes a finished frame, undoes the bit-reversed order, saturates each
  bin to 16+16 bits and sends the bins out over a four-phase handshake
*/
`timescale 1ns/1ps
`include "fft_defs.svh"

module bin_serializer
  import fft_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  frame_t     frame,
  input  logic       frame_valid,
  output logic       frame_ready,
  output bin_t       bin,
  output logic [3:0] bin_index,
  output logic       bin_req,
  input  logic       bin_ack
);

  typedef enum logic [1:0] {
    IDLE,       // waiting for a frame
    START,      // frame loaded, bin 0 goes out next
    REQ,        // bin_req high, waiting for ack
    DROP        // req dropped, waiting for ack to fall
  } ser_state_t;

  ser_state_t state;
  frame_t     held;            // frame being shifted out
  cplx_t      pick;            // element for the current bin

  assign frame_ready = (state == IDLE);

  // stage output sits in bit-reversed order
  assign pick = held[bit_reverse(bin_index)];
  assign bin  = {narrow_bin(pick.re), narrow_bin(pick.im)};

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      bin_req   <= 1'b0;
      bin_index <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (frame_valid)
            state <= START;
        end
        START: begin
          bin_req <= 1'b1;                     // bin 0
          state   <= REQ;
        end
        REQ: begin
          if (bin_ack) begin
            bin_req <= 1'b0;
            state   <= DROP;
          end
        end
        DROP: begin
          if (!bin_ack) begin
            if (bin_index == 4'd15) begin
              bin_index <= '0;                 // frame done
              state     <= IDLE;
            end else begin
              bin_index <= bin_index + 1'b1;
              bin_req   <= 1'b1;               // next bin right away
              state     <= REQ;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // only loaded from idle, so it stays put for all 16 bins
  always_ff @(posedge clk) begin
    if (frame_valid && frame_ready)
      held <= frame;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // sink may sample bin any time req is up
  bin_stable: assert property (
    @(posedge clk) disable iff (rst)
    bin_req && $past(bin_req) |-> $stable(bin) && $stable(bin_index)
  ) else $error("bin or bin_index moved while bin_req was high");

endmodule

/* hdl/fft_top.sv */
/*
  streaming 16-point FFT top level
  collector -> four registered DIF stages -> bin serializer
*/
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_top
  import fft_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // sample side, four-phase req/ack
  input  sample_t    sample,
  input  logic       sample_req,
  output logic       sample_ack,
  // bin side, four-phase req/ack
  output bin_t       bin,
  output logic [3:0] bin_index,
  output logic       bin_req,
  input  logic       bin_ack
);

  // link 0 is collector -> stage 0, link FFT_STAGES is last stage -> serializer
  frame_t link_frame [`FFT_STAGES+1];
  logic   link_valid [`FFT_STAGES+1];
  logic   link_ready [`FFT_STAGES+1];

  sample_collector collector_i (
    .clk         (clk),
    .rst         (rst),
    .sample      (sample),
    .sample_req  (sample_req),
    .sample_ack  (sample_ack),
    .frame       (link_frame[0]),
    .frame_valid (link_valid[0]),
    .frame_ready (link_ready[0])
  );

  ////////////////////////////////////////////////////////////////////////////
  // butterfly pipeline, one frame register per stage
  ////////////////////////////////////////////////////////////////////////////
  for (genvar s = 0; s < `FFT_STAGES; s++) begin : g_stage
    butterfly_stage #(
      .STAGE (s)
    ) stage_i (
      .clk       (clk),
      .rst       (rst),
      .in_frame  (link_frame[s]),
      .in_valid  (link_valid[s]),
      .in_ready  (link_ready[s]),
      .out_frame (link_frame[s+1]),
      .out_valid (link_valid[s+1]),
      .out_ready (link_ready[s+1])
    );
  end

  bin_serializer serializer_i (
    .clk         (clk),
    .rst         (rst),
    .frame       (link_frame[`FFT_STAGES]),
    .frame_valid (link_valid[`FFT_STAGES]),
    .frame_ready (link_ready[`FFT_STAGES]),
    .bin         (bin),
    .bin_index   (bin_index),
    .bin_req     (bin_req),
    .bin_ack     (bin_ack)
  );

endmodule

/* hdl/sample_collector.sv */
/*
  serial to parallel collector
  takes samples over a four-phase handshake and packs 16 into a frame
*/
`timescale 1ns/1ps
`include "fft_defs.svh"

module sample_collector
  import fft_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  sample_t sample,
  input  logic    sample_req,
  output logic    sample_ack,
  output frame_t  frame,
  output logic    frame_valid,
  input  logic    frame_ready
);

  localparam int CNT_W = $clog2(`FFT_N) + 1;   // must hold FFT_N itself

  logic [CNT_W-1:0] fill_cnt;   // slots written so far
  logic             full;
  logic             take;       // capture this cycle

  assign full        = (fill_cnt == `FFT_N);
  assign frame_valid = full;
  // a full frame stalls the ack, which is the input back-pressure
  assign take        = sample_req && !sample_ack && !full;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and fill count
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt   <= '0;
      sample_ack <= 1'b0;
    end else begin
      if (take) begin
        fill_cnt   <= fill_cnt + 1'b1;
        sample_ack <= 1'b1;
      end else if (sample_ack && !sample_req) begin
        sample_ack <= 1'b0;                    // source released, close the cycle
      end
      if (frame_valid && frame_ready)
        fill_cnt <= '0;                        // frame handed to stage 0
    end
  end

  // frame slots, real input so im starts at zero
  always_ff @(posedge clk) begin
    if (take)
      frame[fill_cnt[CNT_W-2:0]] <= '{re: acc_t'(sample), im: '0};
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // ack only ever answers a pending request
  ack_follows_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(sample_ack) |-> $past(sample_req)
  ) else $error("sample_ack rose without sample_req");

endmodule

/* verification/fft_tb.sv */
/*
  testbench for the streaming 16-point FFT
  table driven frames in, LFSR paced sink out, bins checked against a model
*/
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_tb
  import fft_pkg::*;
;

  localparam int NUM_ROWS    = 20;
  localparam int CYCLE_LIMIT = NUM_ROWS * 200;     // generous per-frame budget
  localparam logic [31:0] SEED = 32'h24ef_caf8;

  typedef enum logic [2:0] {K_IMPULSE, K_CONST, K_ALT, K_COS4, K_RANDOM} kind_t;

  typedef struct packed {
    kind_t       kind;
    int          amp;
    logic [511:0] exp_bins;                        // bin n at [n*32 +: 32]
  } row_t;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  sample_t      sample;
  logic         sample_req;
  logic         sample_ack;
  bin_t         bin;
  logic [3:0]   bin_index;
  logic         bin_req;
  logic         bin_ack;

  row_t         table_rows [NUM_ROWS];
  bin_t         exp_q [$];                         // expected bins in frame order
  logic [31:0]  data_lfsr  = SEED;                 // random sample values
  logic [31:0]  delay_lfsr = SEED;                 // sink ack delays
  int           err_count    = 0;
  int           check_count  = 0;
  int           tests_passed = 0;
  int           cycle_count  = 0;
  logic         sink_done    = 1'b0;

  always #4 clk = ~clk;                            // 8 ns period

  fft_top fft_top_i (
    .clk        (clk),
    .rst        (rst),
    .sample     (sample),
    .sample_req (sample_req),
    .sample_ack (sample_ack),
    .bin        (bin),
    .bin_index  (bin_index),
    .bin_req    (bin_req),
    .bin_ack    (bin_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};              // one step per bit
      state = lfsr_step(state);
    end
  endtask

  function automatic logic [511:0] one_bin(input int n, input int re);
    logic [511:0] v;
    v = '0;
    v[n*32 +: 32] = {re[15:0], 16'h0000};          // real only
    return v;
  endfunction

  function automatic logic [511:0] all_bins(input int re);
    logic [511:0] v;
    for (int n = 0; n < `FFT_N; n++)
      v[n*32 +: 32] = {re[15:0], 16'h0000};
    return v;
  endfunction

  function automatic string kind_name(input kind_t kind);
    case (kind)
      K_IMPULSE: return "impulse";
      K_CONST:   return "constant";
      K_ALT:     return "alternating";
      K_COS4:    return "cosine4";
      default:   return "random";
    endcase
  endfunction

  // fixed waveforms where n is the sample position in the frame
  function automatic int pattern_sample(input kind_t kind, input int amp, input int n);
    case (kind)
      K_IMPULSE: return (n == 0) ? amp : 0;
      K_CONST:   return amp;
      K_ALT:     return (n % 2 == 0) ? amp : -amp;
      K_COS4:    return (n % 4 == 0) ? amp : ((n % 4 == 2) ? -amp : 0);
      default:   return 0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model as a straight DIF over the frame
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [511:0] ref_bins(input logic [255:0] smp);
    frame_t       f;
    int           span;
    int           lo;
    int           hi;
    int           k;
    acc_t         dr;
    acc_t         di;
    logic [511:0] res;
    for (int n = 0; n < `FFT_N; n++) begin
      f[n].re = acc_t'(sample_t'(smp[n*16 +: 16]));   // real input sign extended
      f[n].im = '0;
    end
    for (int s = 0; s < `FFT_STAGES; s++) begin
      span = (`FFT_N / 2) >> s;
      for (int base = 0; base < `FFT_N; base += 2 * span) begin
        for (int j = 0; j < span; j++) begin
          lo = base + j;
          hi = lo + span;
          k  = j << s;                             // offset times 2^s
          dr = f[lo].re - f[hi].re;
          di = f[lo].im - f[hi].im;
          f[lo].re = f[lo].re + f[hi].re;
          f[lo].im = f[lo].im + f[hi].im;
          f[hi].re = twiddle_mul(dr, tw_re(k[2:0])) - twiddle_mul(di, tw_im(k[2:0]));
          f[hi].im = twiddle_mul(dr, tw_im(k[2:0])) + twiddle_mul(di, tw_re(k[2:0]));
        end
      end
    end
    for (int n = 0; n < `FFT_N; n++)
      res[n*32 +: 32] = {narrow_bin(f[bit_reverse(n[3:0])].re),
                         narrow_bin(f[bit_reverse(n[3:0])].im)};
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch %s: got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic set_row(input int idx, input kind_t kind, input int amp,
                         input logic [511:0] exp_bins);
    table_rows[idx].kind     = kind;
    table_rows[idx].amp      = amp;
    table_rows[idx].exp_bins = exp_bins;
  endtask

  task automatic fill_table();
    set_row(0,  K_IMPULSE, 1000,  all_bins(1000));
    set_row(1,  K_IMPULSE, -500,  all_bins(-500));
    set_row(2,  K_CONST,   300,   one_bin(0, 16 * 300));
    set_row(3,  K_ALT,     200,   one_bin(8, 16 * 200));
    set_row(4,  K_COS4,    400,   one_bin(4, 8 * 400) | one_bin(12, 8 * 400));
    set_row(5,  K_CONST,   4000,  one_bin(0, 32767));    // 64000 clips
    set_row(6,  K_RANDOM,  2047,  '0);
    set_row(7,  K_RANDOM,  32767, '0);
    set_row(8,  K_RANDOM,  1000,  '0);
    set_row(9,  K_RANDOM,  32767, '0);
    set_row(10, K_RANDOM,  8000,  '0);
    // a long run fills every stage so a full frame stalls the source
    set_row(11, K_RANDOM,  500,   '0);
    set_row(12, K_RANDOM,  16000, '0);
    set_row(13, K_RANDOM,  32767, '0);
    set_row(14, K_RANDOM,  1234,  '0);
    set_row(15, K_RANDOM,  20000, '0);
    set_row(16, K_RANDOM,  100,   '0);
    set_row(17, K_RANDOM,  32767, '0);
    set_row(18, K_RANDOM,  4096,  '0);
    set_row(19, K_RANDOM,  12000, '0);
  endtask

  // four-phase source that starts and ends right after a rising edge
  task automatic drive_sample(input logic [15:0] value);
    sample     <= value;
    sample_req <= 1'b1;
    do @(posedge clk); while (!sample_ack);
    sample_req <= 1'b0;
    do @(posedge clk); while (sample_ack);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // source with frames back to back
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [255:0] smp;
    logic [511:0] exp_bins;
    logic [31:0]  raw;
    int           v;
    sample     <= '0;
    sample_req <= 1'b0;
    fill_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int n = 0; n < `FFT_N; n++) begin
        if (table_rows[r].kind == K_RANDOM) begin
          take_bits(data_lfsr, 16, raw);
          v = int'(raw[15:0] % (2 * table_rows[r].amp + 1)) - table_rows[r].amp;
        end else begin
          v = pattern_sample(table_rows[r].kind, table_rows[r].amp, n);
        end
        smp[n*16 +: 16] = v[15:0];
      end
      if (table_rows[r].kind == K_RANDOM)
        exp_bins = ref_bins(smp);
      else
        exp_bins = table_rows[r].exp_bins;
      for (int n = 0; n < `FFT_N; n++)
        exp_q.push_back(exp_bins[n*32 +: 32]);     // queued before the frame goes in
      for (int n = 0; n < `FFT_N; n++)
        drive_sample(smp[n*16 +: 16]);
    end
    wait (sink_done);
    $display("%0d tests, %0d passed, %0d checks, %0d errors",
             NUM_ROWS, tests_passed, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // sink with a random ack delay of 0 to 3 cycles
  ////////////////////////////////////////////////////////////////////////////
  initial begin : bin_sink
    logic [31:0] dly;
    bin_t        exp_bin;
    int          errs_before;
    bin_ack <= 1'b0;
    wait (!rst);
    for (int fr = 0; fr < NUM_ROWS; fr++) begin
      errs_before = err_count;
      for (int n = 0; n < `FFT_N; n++) begin
        do @(posedge clk); while (!bin_req);
        if (bin_index !== n[3:0]) begin
          err_count++;
          $display("bin index %0d arrived while bin %0d was due", bin_index, n);
        end
        if (exp_q.size() == 0) begin
          err_count++;
          $display("a bin arrived with no expected value waiting");
        end else begin
          exp_bin = exp_q.pop_front();
          check_value($sformatf("bin[%0d]", n), bin, exp_bin);
        end
        take_bits(delay_lfsr, 2, dly);
        repeat (dly) @(posedge clk);
        bin_ack <= 1'b1;
        do @(posedge clk); while (bin_req);         // wait for req to drop
        bin_ack <= 1'b0;
      end
      if (err_count == errs_before) begin
        tests_passed++;
        $display("test %0d %s amp %0d: ok", fr, kind_name(table_rows[fr].kind),
                 table_rows[fr].amp);
      end else begin
        $display("test %0d %s amp %0d: %0d errors", fr, kind_name(table_rows[fr].kind),
                 table_rows[fr].amp, err_count - errs_before);
      end
    end
    sink_done = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin : watchdog
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d expected bins never arrived",
             cycle_count, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule
